/* hdl/riscv_v_pkg.sv */
// --------------------------------------------------
// Vector integer lane package
// Data widths, element size codes, data word views
// and byte index helpers
// --------------------------------------------------
package riscv_v_pkg;

    localparam int RISCV_V_NUM_BYTES_DATA   = 8;
    localparam int BYTE_WIDTH               = 8;
    localparam int RISCV_V_DATA_WIDTH       = RISCV_V_NUM_BYTES_DATA * BYTE_WIDTH;
    localparam int RISCV_V_NUM_VALID_OSIZES = $clog2(RISCV_V_NUM_BYTES_DATA) + 1;

    // Result select codes
    localparam logic [1:0] RISCV_V_SEL_ADD   = 2'd0;
    localparam logic [1:0] RISCV_V_SEL_SHIFT = 2'd1;
    localparam logic [1:0] RISCV_V_SEL_LOGIC = 2'd2;

    typedef logic [BYTE_WIDTH-1:0] Byte_t;
    typedef logic [RISCV_V_NUM_VALID_OSIZES-1:0] osize_vector_t;  // Bit k means 8 << k bits

    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32,
        SEW_64
    } riscv_v_sew_e;

    typedef enum logic [2:0] {
        ADD, SUB, SLL, SRL, SRA, AND, OR, XOR
    } riscv_v_op_e;

    typedef Byte_t [RISCV_V_NUM_BYTES_DATA-1:0] riscv_v_src_byte_vector_t;
    typedef logic [RISCV_V_NUM_BYTES_DATA-1:0] riscv_v_merge_data_t;  // Bit i links bytes i, i+1

    typedef union packed {
        riscv_v_src_byte_vector_t      Byte;
        logic [RISCV_V_DATA_WIDTH-1:0] word;
    } riscv_v_vdata_u;

    // Largest osize at which byte idx is the top byte of an element
    function automatic int f_count_trailing_ones_osize(input int idx, input int num_bytes);
        int count;
        count = 0;
        for (int b = 0; b < $clog2(num_bytes); b++) begin
            if ((count == b) && (((idx >> b) & 1) == 1)) begin
                count = b + 1;
            end
        end
        return count;
    endfunction

    // Largest osize at which byte idx is the bottom byte of an element
    function automatic int f_count_trailing_zeroes_osize(input int idx, input int num_bytes);
        int count;
        count = 0;
        for (int b = 0; b < $clog2(num_bytes); b++) begin
            if ((count == b) && (((idx >> b) & 1) == 0)) begin
                count = b + 1;
            end
        end
        return count;
    endfunction

endpackage : riscv_v_pkg

/* hdl/shifter.sv */
// --------------------------------------------------
// Byte funnel shifter
// Shifts src with bits from the neighbouring byte,
// zero or sign fill
// --------------------------------------------------
module shifter #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]         src,
    input  logic [$clog2(WIDTH)-1:0] shift,
    input  logic                     shift_left,
    input  logic                     shift_arith,
    input  logic [WIDTH-1:0]         shift_in,
    output logic [WIDTH-1:0]         result
);

    logic [WIDTH-1:0]   upper;      // Bits entering from above on a right shift
    logic [2*WIDTH-1:0] funnel_right;
    logic [2*WIDTH-1:0] funnel_left;

    assign upper = shift_arith ? {WIDTH{src[WIDTH-1]}} : shift_in;

    assign funnel_right = {upper, src} >> shift;
    assign funnel_left  = {src, shift_in} << shift;   // shift_in is the lower neighbour here

    assign result = shift_left ? funnel_left[2*WIDTH-1 -: WIDTH] : funnel_right[WIDTH-1:0];

endmodule : shifter

/* hdl/riscv_v_alu_ctrl.sv */
// --------------------------------------------------
// Vector lane control
// Decodes opcode and SEW into unit strobes, element
// size vectors and the byte merge pattern
// --------------------------------------------------
module riscv_v_alu_ctrl (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             in_valid,
    input  riscv_v_pkg::riscv_v_op_e         op,
    input  riscv_v_pkg::riscv_v_sew_e        sew,
    output logic                             is_shift,
    output logic                             is_left,
    output logic                             is_arith,
    output logic                             is_sub,
    output riscv_v_pkg::osize_vector_t       osize_vector,
    output riscv_v_pkg::osize_vector_t       is_less_osize_vector,
    output riscv_v_pkg::osize_vector_t       is_greater_osize_vector,
    output riscv_v_pkg::riscv_v_merge_data_t merge,
    output logic [1:0]                       result_sel,
    output logic                             load,
    output logic                             out_valid
);
    import riscv_v_pkg::*;

    always_comb begin
        is_shift = (op == SLL) || (op == SRL) || (op == SRA);
        is_left  = (op == SLL);
        is_arith = (op == SRA);
        is_sub   = (op == SUB);   // Adder inverts srcb and sets carry in
        case (op)
            ADD, SUB:      result_sel = RISCV_V_SEL_ADD;
            SLL, SRL, SRA: result_sel = RISCV_V_SEL_SHIFT;
            default:       result_sel = RISCV_V_SEL_LOGIC;
        endcase
    end

    // One-hot SEW plus its below and above masks
    always_comb begin
        for (int k = 0; k < RISCV_V_NUM_VALID_OSIZES; k++) begin
            osize_vector[k]            = (int'(sew) == k);
            is_less_osize_vector[k]    = (int'(sew) < k);
            is_greater_osize_vector[k] = (int'(sew) > k);
        end
    end

    // Bytes i and i+1 share an element unless i+1 starts a new one
    always_comb begin
        for (int i = 0; i < RISCV_V_NUM_BYTES_DATA - 1; i++) begin
            merge[i] = is_greater_osize_vector[
                f_count_trailing_zeroes_osize(i + 1, RISCV_V_NUM_BYTES_DATA)];
        end
        merge[RISCV_V_NUM_BYTES_DATA-1] = 1'b0;
    end

    assign load = in_valid;   // Result register captures on the issue edge

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

endmodule : riscv_v_alu_ctrl

/* hdl/riscv_v_shifter.sv */
// --------------------------------------------------
// Element aware vector shifter
// Byte mux stages move whole bytes, then per-byte
// funnel shifters finish the bit count
// --------------------------------------------------
module riscv_v_shifter #(
    parameter int NUM_BYTES = riscv_v_pkg::RISCV_V_NUM_BYTES_DATA
) (
    input  logic                                  is_shift,
    input  logic                                  is_left,
    input  logic                                  is_arith,
    input  riscv_v_pkg::osize_vector_t            osize_vector,
    input  riscv_v_pkg::osize_vector_t            is_less_osize_vector,
    input  riscv_v_pkg::osize_vector_t            is_greater_osize_vector,
    input  riscv_v_pkg::riscv_v_vdata_u           srca_data,
    input  riscv_v_pkg::riscv_v_vdata_u           srcb_data,
    input  riscv_v_pkg::riscv_v_merge_data_t      srca_merge,
    output riscv_v_pkg::riscv_v_src_byte_vector_t result
);
    import riscv_v_pkg::*;

    localparam int LOG_BYTES = $clog2(NUM_BYTES);
    localparam int BIT_SEL_W = $clog2(BYTE_WIDTH);
    localparam int SEL_W     = BIT_SEL_W + LOG_BYTES;

    Byte_t                srcb_swizzle [NUM_BYTES];
    logic [NUM_BYTES-1:0] sel_merge;              // Merge bits in working byte order
    logic [SEL_W-1:0]     byte_sel [NUM_BYTES];   // Shift amount seen by each byte
    Byte_t                stage_data [LOG_BYTES+1][NUM_BYTES];
    Byte_t                shift_in [NUM_BYTES];
    Byte_t                shifted [NUM_BYTES];
    logic [NUM_BYTES-1:0] byte_arith;

    // Left shifts run on the byte reversed word, so bytes always move down
    for (genvar b = 0; b < NUM_BYTES; b++) begin : gen_swizzle
        assign srcb_swizzle[b]  = srcb_data.Byte[NUM_BYTES-1-b];
        assign stage_data[0][b] = (is_left ? srca_data.Byte[NUM_BYTES-1-b] : srca_data.Byte[b])
                                  & {BYTE_WIDTH{is_shift}};   // Held at zero for other ops
    end

    for (genvar b = 0; b < NUM_BYTES - 1; b++) begin : gen_sel_merge
        assign sel_merge[b] = is_left ? srca_merge[NUM_BYTES-2-b] : srca_merge[b];
    end
    assign sel_merge[NUM_BYTES-1] = 1'b0;

    // Amount comes from the element's bottom byte in srcb
    for (genvar b = 0; b < NUM_BYTES; b++) begin : gen_amount
        localparam int TZ = f_count_trailing_zeroes_osize(b, NUM_BYTES);
        localparam int TO = f_count_trailing_ones_osize(b, NUM_BYTES);
        logic [SEL_W-1:0] amt_right;
        logic [SEL_W-1:0] amt_left;

        always_comb begin
            amt_right = srcb_data.Byte[b][SEL_W-1:0] & {SEL_W{~is_greater_osize_vector[TZ]}};
            amt_left  = srcb_swizzle[b][SEL_W-1:0] & {SEL_W{~is_greater_osize_vector[TO]}};
            for (int k = 1; k <= LOG_BYTES; k++) begin
                if (k > TZ) begin
                    amt_right |= srcb_data.Byte[(b >> k) << k][SEL_W-1:0]
                                 & {SEL_W{osize_vector[k]}};
                end
                if (k > TO) begin   // Bottom byte sits at the top of the reversed group
                    amt_left |= srcb_swizzle[b | ((1 << k) - 1)][SEL_W-1:0]
                                & {SEL_W{osize_vector[k]}};
                end
            end
        end
        assign byte_sel[b] = is_left ? amt_left : amt_right;
    end

    // Stage m moves bytes down by 2**m
    for (genvar m = 0; m < LOG_BYTES; m++) begin : gen_stage
        for (genvar b = 0; b < NUM_BYTES; b++) begin : gen_mux
            localparam int STEP = 2 ** m;
            localparam int TOP  = ((b / STEP) + 1) * STEP - 1;   // Top byte of aligned group
            localparam int SRC  = (b + STEP < NUM_BYTES) ? b + STEP : b;
            logic  move;
            logic  link;
            Byte_t fill;

            if (b + STEP < NUM_BYTES) begin : gen_link
                assign link = &sel_merge[b +: STEP];   // Source byte in the same element
            end else begin : gen_edge
                assign link = 1'b0;
            end
            // Only when the element is wider than the step
            assign move = byte_sel[b][BIT_SEL_W+m] & ~is_less_osize_vector[m+1];
            assign fill = {BYTE_WIDTH{stage_data[m][TOP][BYTE_WIDTH-1] & is_arith}};
            assign stage_data[m+1][b] = !move ? stage_data[m][b] :
                                        link  ? stage_data[m][SRC] : fill;
        end
    end

    for (genvar b = 0; b < NUM_BYTES; b++) begin : gen_bytes
        if (b < NUM_BYTES - 1) begin : gen_in
            assign shift_in[b] = stage_data[LOG_BYTES][b+1] & {BYTE_WIDTH{sel_merge[b]}};
        end else begin : gen_top
            assign shift_in[b] = '0;
        end
        assign byte_arith[b] = is_arith & ~sel_merge[b];   // Sign fill on element top byte

        shifter #(
            .WIDTH(BYTE_WIDTH)
        ) i_byte_shifter (
            .src        (stage_data[LOG_BYTES][b]),
            .shift      (byte_sel[b][BIT_SEL_W-1:0]),
            .shift_left (is_left),
            .shift_arith(byte_arith[b]),
            .shift_in   (shift_in[b]),
            .result     (shifted[b])
        );

        // Undo the reversal for left shifts
        assign result[b] = is_left ? shifted[NUM_BYTES-1-b] : shifted[b];
    end

endmodule : riscv_v_shifter

/* hdl/riscv_v_adder.sv */
// --------------------------------------------------
// Element segmented adder
// Byte slices with the carry chain cut at element
// boundaries, subtract by inverting srcb
// --------------------------------------------------
module riscv_v_adder #(
    parameter int NUM_BYTES = riscv_v_pkg::RISCV_V_NUM_BYTES_DATA
) (
    input  riscv_v_pkg::riscv_v_vdata_u      srca_data,
    input  riscv_v_pkg::riscv_v_vdata_u      srcb_data,
    input  riscv_v_pkg::riscv_v_merge_data_t merge,
    input  logic                             is_sub,
    output riscv_v_pkg::riscv_v_vdata_u      sum
);
    import riscv_v_pkg::*;

    logic [NUM_BYTES-1:0] carry_in;
    logic [NUM_BYTES-1:0] carry_out;

    assign carry_in[0] = is_sub;   // The +1 of two's complement

    for (genvar b = 1; b < NUM_BYTES; b++) begin : gen_carry
        // A new element restarts the chain
        assign carry_in[b] = merge[b-1] ? carry_out[b-1] : is_sub;
    end

    for (genvar b = 0; b < NUM_BYTES; b++) begin : gen_slice
        Byte_t               operand_b;
        logic [BYTE_WIDTH:0] slice_sum;

        assign operand_b = srcb_data.Byte[b] ^ {BYTE_WIDTH{is_sub}};
        assign slice_sum = {1'b0, srca_data.Byte[b]} + {1'b0, operand_b}
                           + {{BYTE_WIDTH{1'b0}}, carry_in[b]};

        assign carry_out[b] = slice_sum[BYTE_WIDTH];
        assign sum.Byte[b]  = slice_sum[BYTE_WIDTH-1:0];
    end

endmodule : riscv_v_adder

/* hdl/riscv_v_alu_result.sv */
// --------------------------------------------------
// Vector lane result stage
// Bitwise ops, unit select and the output register
// --------------------------------------------------
module riscv_v_alu_result (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        load,
    input  logic [1:0]                                  result_sel,
    input  riscv_v_pkg::riscv_v_op_e                    op,
    input  riscv_v_pkg::riscv_v_vdata_u                 srca_data,
    input  riscv_v_pkg::riscv_v_vdata_u                 srcb_data,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t       shift_result,
    input  riscv_v_pkg::riscv_v_vdata_u                 add_result,
    output logic [riscv_v_pkg::RISCV_V_DATA_WIDTH-1:0] result
);
    import riscv_v_pkg::*;

    logic [RISCV_V_DATA_WIDTH-1:0] logic_result;
    logic [RISCV_V_DATA_WIDTH-1:0] next_result;

    // SEW does not matter for bitwise ops
    always_comb begin
        case (op)
            AND:     logic_result = srca_data.word & srcb_data.word;
            OR:      logic_result = srca_data.word | srcb_data.word;
            default: logic_result = srca_data.word ^ srcb_data.word;
        endcase
    end

    always_comb begin
        case (result_sel)
            RISCV_V_SEL_ADD:   next_result = add_result.word;
            RISCV_V_SEL_SHIFT: next_result = shift_result;
            default:           next_result = logic_result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result <= '0;
        end else if (load) begin
            result <= next_result;   // Held until the next issue
        end
    end

endmodule : riscv_v_alu_result

/* hdl/riscv_v_alu.sv */
// --------------------------------------------------
// Vector integer lane top
// Add, sub, shifts and bitwise ops on 8 to 64 bit
// elements, result one cycle after in_valid
// --------------------------------------------------
module riscv_v_alu #(
    parameter int NUM_BYTES = riscv_v_pkg::RISCV_V_NUM_BYTES_DATA
) (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        in_valid,
    input  riscv_v_pkg::riscv_v_op_e                    op,
    input  riscv_v_pkg::riscv_v_sew_e                   sew,
    input  logic [riscv_v_pkg::RISCV_V_DATA_WIDTH-1:0] srca,
    input  logic [riscv_v_pkg::RISCV_V_DATA_WIDTH-1:0] srcb,
    output logic                                        out_valid,
    output logic [riscv_v_pkg::RISCV_V_DATA_WIDTH-1:0] result
);
    import riscv_v_pkg::*;

    logic                     is_shift;
    logic                     is_left;
    logic                     is_arith;
    logic                     is_sub;
    osize_vector_t            osize_vector;
    osize_vector_t            is_less_osize_vector;
    osize_vector_t            is_greater_osize_vector;
    riscv_v_merge_data_t      merge;
    logic [1:0]               result_sel;
    logic                     load;
    riscv_v_src_byte_vector_t shift_result;
    riscv_v_vdata_u           add_result;

    riscv_v_alu_ctrl i_ctrl (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .in_valid               (in_valid),
        .op                     (op),
        .sew                    (sew),
        .is_shift               (is_shift),
        .is_left                (is_left),
        .is_arith               (is_arith),
        .is_sub                 (is_sub),
        .osize_vector           (osize_vector),
        .is_less_osize_vector   (is_less_osize_vector),
        .is_greater_osize_vector(is_greater_osize_vector),
        .merge                  (merge),
        .result_sel             (result_sel),
        .load                   (load),
        .out_valid              (out_valid)
    );

    riscv_v_shifter #(
        .NUM_BYTES(NUM_BYTES)
    ) i_shifter (
        .is_shift               (is_shift),
        .is_left                (is_left),
        .is_arith               (is_arith),
        .osize_vector           (osize_vector),
        .is_less_osize_vector   (is_less_osize_vector),
        .is_greater_osize_vector(is_greater_osize_vector),
        .srca_data              (srca),
        .srcb_data              (srcb),
        .srca_merge             (merge),
        .result                 (shift_result)
    );

    riscv_v_adder #(
        .NUM_BYTES(NUM_BYTES)
    ) i_adder (
        .srca_data(srca),
        .srcb_data(srcb),
        .merge    (merge),
        .is_sub   (is_sub),
        .sum      (add_result)
    );

    riscv_v_alu_result i_result (
        .clk         (clk),
        .rst_n       (rst_n),
        .load        (load),
        .result_sel  (result_sel),
        .op          (op),
        .srca_data   (srca),
        .srcb_data   (srcb),
        .shift_result(shift_result),
        .add_result  (add_result),
        .result      (result)
    );

endmodule : riscv_v_alu

/* dv/tb_riscv_v_alu.sv */
// --------------------------------------------------
// Vector integer lane testbench
// Random and directed ops checked by assertions
// against an element-wise reference model
// --------------------------------------------------
module tb_riscv_v_alu;
    import riscv_v_pkg::*;

    localparam int DW             = RISCV_V_DATA_WIDTH;
    localparam int RESET_CYCLES   = 8;
    localparam int NUM_RANDOM     = 300;
    localparam int DIRECTED_OPS   = 256;   // Upper bound over the directed tests
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 * (NUM_RANDOM + DIRECTED_OPS) + 200;

    logic          clk;
    logic          rst_n;
    logic          in_valid;
    riscv_v_op_e   op;
    riscv_v_sew_e  sew;
    logic [DW-1:0] srca;
    logic [DW-1:0] srcb;
    logic          out_valid;
    logic [DW-1:0] result;

    logic [DW-1:0] exp_result;   // Model value of the op being driven
    logic [DW-1:0] exp_q;        // Model value at the check edge
    logic          seen_issue;
    int            seed = 32'h6a36_8fbe;
    int            error_count = 0;
    int            op_count = 0;
    int            test_count = 0;
    int            test_ops;
    int            test_err_base;
    string         cur_test = "reset";

    riscv_v_alu #(
        .NUM_BYTES(RISCV_V_NUM_BYTES_DATA)
    ) i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .op       (op),
        .sew      (sew),
        .srca     (srca),
        .srcb     (srcb),
        .out_valid(out_valid),
        .result   (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (in_valid) exp_q <= exp_result;
    end

    a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_issue |-> (!out_valid && result == '0))
    else begin
        $display("%s: out_valid or result not idle after reset", cur_test);
        error_count++;
    end

    a_valid_rise: assert property (@(posedge clk) disable iff (!rst_n) in_valid |=> out_valid)
    else begin
        $display("%s: out_valid did not rise one cycle after in_valid", cur_test);
        error_count++;
    end

    a_valid_low: assert property (@(posedge clk) disable iff (!rst_n) !in_valid |=> !out_valid)
    else begin
        $display("%s: out_valid high without an issue", cur_test);
        error_count++;
    end

    a_result: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |=> (result == exp_q))
    else begin
        $display("ERROR %s: expected %h, actual %h", cur_test, $sampled(exp_q),
                 $sampled(result));
        error_count++;
    end

    // Element-wise reference, amount taken modulo the element width
    function automatic logic [DW-1:0] model(input riscv_v_op_e o, input riscv_v_sew_e s,
                                            input logic [DW-1:0] a, input logic [DW-1:0] b);
        int                   ew;
        int                   amt;
        logic [DW-1:0]        mask;
        logic [DW-1:0]        ea;
        logic [DW-1:0]        eb;
        logic [DW-1:0]        r;
        logic signed [DW-1:0] sx;
        logic [DW-1:0]        res;
        ew   = 8 << int'(s);
        mask = (ew == DW) ? {DW{1'b1}} : ((DW'(1) << ew) - DW'(1));
        res  = '0;
        case (o)
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            default: ;
        endcase
        for (int e = 0; e < DW / ew; e++) begin
            ea  = (a >> (e * ew)) & mask;
            eb  = (b >> (e * ew)) & mask;
            amt = int'(eb[5:0]) % ew;
            sx  = ea[ew-1] ? (ea | ~mask) : ea;   // Sign extended element
            case (o)
                ADD:     r = ea + eb;
                SUB:     r = ea - eb;
                SLL:     r = ea << amt;
                SRL:     r = ea >> amt;
                default: r = sx >>> amt;
            endcase
            res |= (r & mask) << (e * ew);
        end
        return res;
    endfunction

    // Same value in every element
    function automatic logic [DW-1:0] splat(input riscv_v_sew_e s, input logic [DW-1:0] val);
        int            ew;
        logic [DW-1:0] w;
        ew = 8 << int'(s);
        w  = '0;
        for (int e = 0; e < DW / ew; e++) begin
            w |= val << (e * ew);
        end
        return w;
    endfunction

    function automatic logic [DW-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic issue(input riscv_v_op_e o, input riscv_v_sew_e s,
                         input logic [DW-1:0] a, input logic [DW-1:0] b);
        @(posedge clk);
        #1;
        in_valid   = 1'b1;
        op         = o;
        sew        = s;
        srca       = a;
        srcb       = b;
        exp_result = model(o, s, a, b);
        seen_issue = 1'b1;
        op_count++;
        test_ops++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test      = name;
        test_ops      = 0;
        test_err_base = error_count;
    endtask

    // Last result is checked on the edge after the drop of in_valid
    task automatic end_test();
        idle_cycle();
        @(posedge clk);
        #1;
        $display("%s: %0d ops, %0d errors", cur_test, test_ops, error_count - test_err_base);
        test_count++;
    endtask

    task automatic run_shift_amounts(input riscv_v_op_e o, input riscv_v_sew_e s,
                                     input logic [DW-1:0] a);
        int ew;
        ew = 8 << int'(s);
        for (int amt = 0; amt < ew; amt += 8) begin   // Zero and whole bytes
            issue(o, s, a, splat(s, DW'(amt)));
        end
        issue(o, s, a, splat(s, DW'(ew - 1)));
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, tests did not finish", TIMEOUT_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        riscv_v_sew_e s;
        riscv_v_op_e  sel_op;
        logic [31:0]  r;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        op         = ADD;
        sew        = SEW_8;
        srca       = '0;
        srcb       = '0;
        exp_result = '0;
        exp_q      = '0;
        seen_issue = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (3) @(posedge clk);   // Idle window for the reset check

        start_test("valid_timing");
        issue(ADD, SEW_8, rand64(), rand64());
        idle_cycle();
        idle_cycle();
        issue(XOR, SEW_16, rand64(), rand64());
        issue(SUB, SEW_32, rand64(), rand64());   // Back to back
        issue(SLL, SEW_64, rand64(), rand64());
        end_test();

        start_test("add_sub");
        for (int k = 0; k < 4; k++) begin
            s = riscv_v_sew_e'(2'(k));
            for (int j = 0; j < 2; j++) begin
                sel_op = (j == 0) ? ADD : SUB;
                issue(sel_op, s, {DW{1'b1}}, splat(s, DW'(1)));   // Carry at every boundary
                issue(sel_op, s, '0, splat(s, DW'(1)));
                issue(sel_op, s, 64'h7f7f_7f7f_7f7f_7f7f, 64'h0101_0101_0101_0101);
                issue(sel_op, s, rand64(), rand64());
                issue(sel_op, s, rand64(), rand64());
            end
        end
        end_test();

        start_test("sll");
        for (int k = 0; k < 4; k++) begin
            s = riscv_v_sew_e'(2'(k));
            run_shift_amounts(SLL, s, 64'h0123_4567_89ab_cdef);
            run_shift_amounts(SLL, s, rand64());
            issue(SLL, s, rand64(), splat(s, DW'((8 << k) + 3)));   // Amount past width
        end
        end_test();

        start_test("srl_sra");
        for (int k = 0; k < 4; k++) begin
            s = riscv_v_sew_e'(2'(k));
            for (int j = 0; j < 2; j++) begin
                sel_op = (j == 0) ? SRL : SRA;
                run_shift_amounts(sel_op, s, 64'hf0e1_d2c3_b4a5_9687);   // Negative at all SEW
                run_shift_amounts(sel_op, s, 64'h8000_0000_0000_0001);
                run_shift_amounts(sel_op, s, rand64());
            end
        end
        end_test();

        start_test("logic");
        for (int k = 0; k < 4; k++) begin
            s = riscv_v_sew_e'(2'(k));
            issue(AND, s, rand64(), rand64());
            issue(OR, s, rand64(), rand64());
            issue(XOR, s, rand64(), rand64());
            issue(AND, s, {DW{1'b1}}, rand64());
            issue(OR, s, '0, rand64());
            issue(XOR, s, rand64(), {DW{1'b1}});
        end
        end_test();

        start_test("random_mix");
        for (int n = 0; n < NUM_RANDOM; n++) begin
            r = $random(seed);
            issue(riscv_v_op_e'(r[2:0]), riscv_v_sew_e'(r[5:4]), rand64(), rand64());
        end
        end_test();

        $display("Tests: %0d, operations: %0d, errors: %0d", test_count, op_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : tb_riscv_v_alu

/* files.f */
hdl/riscv_v_pkg.sv
hdl/shifter.sv
hdl/riscv_v_alu_ctrl.sv
hdl/riscv_v_shifter.sv
hdl/riscv_v_adder.sv
hdl/riscv_v_alu_result.sv
hdl/riscv_v_alu.sv
dv/tb_riscv_v_alu.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_riscv_v_alu
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
